//--- src.f
logic/axi_ram_pkg.sv
logic/axi_burst_addr.sv
logic/axi_ram_wr_ctrl.sv
logic/axi_ram_rd_ctrl.sv
logic/axi_r_fifo2.sv
logic/axi_ram_bridge.sv
verif/tb_axi_ram_bridge.sv

//--- Bender.yml
package:
  name: axi_ram_bridge

sources:
  - logic/axi_ram_pkg.sv
  - logic/axi_burst_addr.sv
  - logic/axi_ram_wr_ctrl.sv
  - logic/axi_ram_rd_ctrl.sv
  - logic/axi_r_fifo2.sv
  - logic/axi_ram_bridge.sv
  - target: test
    files:
      - verif/tb_axi_ram_bridge.sv

//--- verif/tb_axi_ram_bridge.sv
// AXI RAM bridge testbench
module tb_axi_ram_bridge;

    timeunit 1ns;
    timeprecision 100ps;

    import axi_ram_pkg::*;

    localparam int unsigned addr_w  = 32;
    localparam int unsigned data_w  = 32;
    localparam int unsigned id_w    = 4;
    localparam int unsigned rd_lat  = 2;
    localparam int          TIMEOUT = 200;

    logic                clk_i, rst_ni;
    logic                aw_valid_i, aw_ready_o;
    logic [id_w-1:0]     aw_id_i;
    logic [addr_w-1:0]   aw_addr_i;
    len_t                aw_len_i;
    burst_e              aw_burst_i;
    logic                w_valid_i, w_ready_o, w_last_i;
    logic [data_w-1:0]   w_data_i;
    logic [data_w/8-1:0] w_strb_i;
    logic                b_valid_o, b_ready_i;
    logic [id_w-1:0]     b_id_o;
    resp_e               b_resp_o;
    logic                ar_valid_i, ar_ready_o;
    logic [id_w-1:0]     ar_id_i;
    logic [addr_w-1:0]   ar_addr_i;
    len_t                ar_len_i;
    burst_e              ar_burst_i;
    logic                r_valid_o, r_ready_i, r_last_o;
    logic [data_w-1:0]   r_data_o;
    logic [id_w-1:0]     r_id_o;
    resp_e               r_resp_o;
    logic [addr_w-1:0]   ram_addr_o;
    logic [data_w-1:0]   ram_din_o, ram_wmask_o, ram_dout_i;
    logic                ram_wren_o, ram_rden_o;

    // RAM contents, expected contents and the two read stages
    logic [data_w-1:0]   mem     [256];
    logic [data_w-1:0]   exp_mem [256];
    logic [data_w-1:0]   rd_stage0, rd_stage1;

    // Beat data for the next write burst and expected data for the next read
    logic [data_w-1:0]   wr_data [256];
    logic [data_w/8-1:0] wr_strb [256];
    logic [data_w-1:0]   rd_exp  [256];

    integer seed;
    int     chk_cnt, err_cnt, to_cnt;
    logic   timed_out;

    axi_ram_bridge #(
        .addr_w(addr_w), .data_w(data_w), .id_w(id_w), .read_latency(rd_lat)
    ) uut (
        .clk_i, .rst_ni,
        .aw_valid_i, .aw_ready_o, .aw_id_i, .aw_addr_i, .aw_len_i, .aw_burst_i,
        .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i, .w_last_i,
        .b_valid_o, .b_ready_i, .b_id_o, .b_resp_o,
        .ar_valid_i, .ar_ready_o, .ar_id_i, .ar_addr_i, .ar_len_i, .ar_burst_i,
        .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_resp_o, .r_last_o,
        .ram_addr_o, .ram_din_o, .ram_wmask_o, .ram_wren_o, .ram_rden_o, .ram_dout_i
    );

    // ------------------------------------------------------------------------
    // Clock and RAM model
    // ------------------------------------------------------------------------

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Initial word mixes every address bit into each byte
    function automatic logic [data_w-1:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'ha5, a, ~a, a + 8'h3c};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i]     = fill_word(i);
            exp_mem[i] = fill_word(i);
        end
        rd_stage0 = '0;
        rd_stage1 = '0;
    end

    // Masked write and read data two edges after the read strobe
    always @(posedge clk_i) begin
        if (ram_wren_o) begin
            mem[ram_addr_o[9:2]] <= (mem[ram_addr_o[9:2]] & ~ram_wmask_o)
                                  | (ram_din_o & ram_wmask_o);
        end
        if (ram_rden_o) begin
            rd_stage0 <= mem[ram_addr_o[9:2]];
        end
        rd_stage1 <= rd_stage0;
    end

    assign ram_dout_i = rd_stage1;

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    task automatic check_data(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                              input logic [addr_w-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input logic [id_w-1:0] got,
                            input logic [id_w-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input resp_e got, input resp_e exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: no %s within %0d cycles at t=%0t", what, TIMEOUT, $time);
        to_cnt++;
        timed_out = 1'b1;
    endtask

    // Word index of a beat where only INCR moves on by one word
    function automatic int word_of(input logic [addr_w-1:0] addr, input int beat,
                                   input burst_e burst);
        if (burst == BURST_INCR) begin
            return (int'(addr[9:2]) + beat) % 256;
        end
        return int'(addr[9:2]);
    endfunction

    task automatic load_expected(input logic [addr_w-1:0] addr, input len_t len,
                                 input burst_e burst);
        for (int b = 0; b <= int'(len); b++) begin
            rd_exp[b] = exp_mem[word_of(addr, b, burst)];
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus drivers
    // ------------------------------------------------------------------------

    task automatic axi_write_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                                   input len_t len, input burst_e burst);
        int                n;
        int                w;
        logic [addr_w-1:0] exp_addr;
        if (timed_out) return;
        aw_valid_i = 1'b1;
        aw_id_i    = id;
        aw_addr_i  = addr;
        aw_len_i   = len;
        aw_burst_i = burst;
        n = 0;
        @(negedge clk_i);
        while (!aw_ready_o && !timed_out) begin
            n++;
            if (n > TIMEOUT) note_timeout("AWREADY");
            else @(negedge clk_i);
        end
        @(posedge clk_i);
        #5;
        aw_valid_i = 1'b0;
        for (int beat = 0; beat <= int'(len) && !timed_out; beat++) begin
            w_valid_i = 1'b1;
            w_data_i  = wr_data[beat];
            w_strb_i  = wr_strb[beat];
            w_last_i  = (beat == int'(len));
            n = 0;
            @(negedge clk_i);
            while (!w_ready_o && !timed_out) begin
                n++;
                if (n > TIMEOUT) note_timeout("WREADY");
                else @(negedge clk_i);
            end
            if (timed_out) break;
            // Beat goes to the RAM in its handshake cycle at the stepped address
            w = word_of(addr, beat, burst);
            exp_addr = (burst == BURST_INCR) ? addr + addr_w'(beat * (data_w / 8)) : addr;
            check_bit("ram_wren_o", ram_wren_o, 1'b1);
            check_addr("ram_addr_o", ram_addr_o, exp_addr);
            for (int k = 0; k < data_w / 8; k++) begin
                if (wr_strb[beat][k]) exp_mem[w][k*8 +: 8] = wr_data[beat][k*8 +: 8];
            end
            @(posedge clk_i);
            #5;
        end
        w_valid_i = 1'b0;
        w_last_i  = 1'b0;
        if (timed_out) return;
        b_ready_i = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (!b_valid_o && !timed_out) begin
            n++;
            if (n > TIMEOUT) note_timeout("BVALID");
            else @(negedge clk_i);
        end
        check_id("b_id_o", b_id_o, id);
        check_resp("b_resp_o", b_resp_o, RESP_OKAY);
        @(posedge clk_i);
        #5;
        b_ready_i = 1'b0;
    endtask

    // Compares each beat with rd_exp and may stall RREADY at random
    task automatic axi_read_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                                  input len_t len, input burst_e burst, input bit rand_ready);
        int          n;
        int          beat;
        logic [31:0] rnd;
        if (timed_out) return;
        ar_valid_i = 1'b1;
        ar_id_i    = id;
        ar_addr_i  = addr;
        ar_len_i   = len;
        ar_burst_i = burst;
        n = 0;
        @(negedge clk_i);
        while (!ar_ready_o && !timed_out) begin
            n++;
            if (n > TIMEOUT) note_timeout("ARREADY");
            else @(negedge clk_i);
        end
        @(posedge clk_i);
        #5;
        ar_valid_i = 1'b0;
        r_ready_i  = 1'b1;
        beat = 0;
        n = 0;
        while (beat <= int'(len) && !timed_out) begin
            @(negedge clk_i);
            if (r_valid_o && r_ready_i) begin
                check_data("r_data_o", r_data_o, rd_exp[beat]);
                check_id("r_id_o", r_id_o, id);
                check_resp("r_resp_o", r_resp_o, RESP_OKAY);
                check_bit("r_last_o", r_last_o, beat == int'(len));
                beat++;
                n = 0;
            end else begin
                n++;
                if (n > TIMEOUT) note_timeout("R beat");
            end
            @(posedge clk_i);
            #5;
            rnd = $random(seed);
            r_ready_i = rand_ready ? rnd[0] : 1'b1;
        end
        r_ready_i = 1'b0;
        if (timed_out) return;
        // No beat beyond the burst and the controller back in idle
        @(negedge clk_i);
        check_bit("r_valid_o after burst", r_valid_o, 1'b0);
        check_bit("ar_ready_o after burst", ar_ready_o, 1'b1);
        @(posedge clk_i);
        #5;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_after_reset();
        @(negedge clk_i);
        check_bit("aw_ready_o", aw_ready_o, 1'b1);
        check_bit("ar_ready_o", ar_ready_o, 1'b1);
        check_bit("w_ready_o", w_ready_o, 1'b0);
        check_bit("b_valid_o", b_valid_o, 1'b0);
        check_bit("r_valid_o", r_valid_o, 1'b0);
        check_bit("ram_wren_o", ram_wren_o, 1'b0);
        check_bit("ram_rden_o", ram_rden_o, 1'b0);
        @(posedge clk_i);
        #5;
    endtask

    task automatic test_single();
        wr_data[0] = 32'hdead_beef;
        wr_strb[0] = 4'hf;
        axi_write_burst(4'h3, 32'h0000_0040, 8'd0, BURST_INCR);
        // Full strobe so the word read back is exactly the data written
        rd_exp[0] = 32'hdead_beef;
        axi_read_burst(4'h5, 32'h0000_0040, 8'd0, BURST_INCR, 1'b0);
    endtask

    task automatic test_incr_strobes();
        logic [31:0] rnd;
        for (int b = 0; b < 4; b++) begin
            wr_data[b] = $random(seed);
            rnd = $random(seed);
            // Keep every strobe partial
            wr_strb[b] = (rnd[3:0] == 4'hf || rnd[3:0] == 4'h0) ? 4'hb : rnd[3:0];
        end
        axi_write_burst(4'h1, 32'h0000_0080, 8'd3, BURST_INCR);
        load_expected(32'h0000_0080, 8'd3, BURST_INCR);
        axi_read_burst(4'h2, 32'h0000_0080, 8'd3, BURST_INCR, 1'b0);
    endtask

    task automatic test_fixed();
        wr_data[0] = 32'h1111_1111;
        wr_strb[0] = 4'hf;
        wr_data[1] = 32'h2222_2222;
        wr_strb[1] = 4'h6;
        wr_data[2] = 32'h3333_3333;
        wr_strb[2] = 4'h1;
        axi_write_burst(4'h6, 32'h0000_00c0, 8'd2, BURST_FIXED);
        // Later beats overwrite only their strobed bytes of the first full word
        for (int b = 0; b < 3; b++) begin
            rd_exp[b] = 32'h1122_2233;
        end
        axi_read_burst(4'ha, 32'h0000_00c0, 8'd2, BURST_FIXED, 1'b0);
    endtask

    task automatic test_read_backpressure();
        load_expected(32'h0000_0100, 8'd7, BURST_INCR);
        axi_read_burst(4'hb, 32'h0000_0100, 8'd7, BURST_INCR, 1'b1);
    endtask

    // Disjoint ranges keep the expected data independent of arbitration
    task automatic test_concurrent();
        for (int b = 0; b < 4; b++) begin
            wr_data[b] = $random(seed);
            wr_strb[b] = 4'hf;
        end
        load_expected(32'h0000_0300, 8'd3, BURST_INCR);
        fork
            axi_write_burst(4'h7, 32'h0000_0200, 8'd3, BURST_INCR);
            axi_read_burst(4'h8, 32'h0000_0300, 8'd3, BURST_INCR, 1'b0);
        join
        load_expected(32'h0000_0200, 8'd3, BURST_INCR);
        axi_read_burst(4'h9, 32'h0000_0200, 8'd3, BURST_INCR, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed       = 53;
        chk_cnt    = 0;
        err_cnt    = 0;
        to_cnt     = 0;
        timed_out  = 1'b0;
        rst_ni     = 1'b0;
        aw_valid_i = 1'b0;
        aw_id_i    = '0;
        aw_addr_i  = '0;
        aw_len_i   = '0;
        aw_burst_i = BURST_INCR;
        w_valid_i  = 1'b0;
        w_data_i   = '0;
        w_strb_i   = '0;
        w_last_i   = 1'b0;
        b_ready_i  = 1'b0;
        ar_valid_i = 1'b0;
        ar_id_i    = '0;
        ar_addr_i  = '0;
        ar_len_i   = '0;
        ar_burst_i = BURST_INCR;
        r_ready_i  = 1'b0;
        repeat (4) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;
        test_after_reset();
        test_single();
        test_incr_strobes();
        test_fixed();
        test_read_backpressure();
        test_concurrent();
        $display("Checks: %0d  errors: %0d  timeouts: %0d", chk_cnt, err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- logic/axi_ram_bridge.sv
// AXI4 slave to RAM bridge
module axi_ram_bridge #(
    parameter int unsigned addr_w       = axi_ram_pkg::DEF_ADDR_W,
    parameter int unsigned data_w       = axi_ram_pkg::DEF_DATA_W,
    parameter int unsigned id_w         = axi_ram_pkg::DEF_ID_W,
    parameter int unsigned read_latency = axi_ram_pkg::DEF_RD_LAT
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    // AW channel
    input  logic                aw_valid_i,
    output logic                aw_ready_o,
    input  logic [id_w-1:0]     aw_id_i,
    input  logic [addr_w-1:0]   aw_addr_i,
    input  axi_ram_pkg::len_t   aw_len_i,
    input  axi_ram_pkg::burst_e aw_burst_i,
    // W channel
    input  logic                w_valid_i,
    output logic                w_ready_o,
    input  logic [data_w-1:0]   w_data_i,
    input  logic [data_w/8-1:0] w_strb_i,
    input  logic                w_last_i,
    // B channel
    output logic                b_valid_o,
    input  logic                b_ready_i,
    output logic [id_w-1:0]     b_id_o,
    output axi_ram_pkg::resp_e  b_resp_o,
    // AR channel
    input  logic                ar_valid_i,
    output logic                ar_ready_o,
    input  logic [id_w-1:0]     ar_id_i,
    input  logic [addr_w-1:0]   ar_addr_i,
    input  axi_ram_pkg::len_t   ar_len_i,
    input  axi_ram_pkg::burst_e ar_burst_i,
    // R channel
    output logic                r_valid_o,
    input  logic                r_ready_i,
    output logic [data_w-1:0]   r_data_o,
    output logic [id_w-1:0]     r_id_o,
    output axi_ram_pkg::resp_e  r_resp_o,
    output logic                r_last_o,
    // Single-port RAM
    output logic [addr_w-1:0]   ram_addr_o,
    output logic [data_w-1:0]   ram_din_o,
    output logic [data_w-1:0]   ram_wmask_o,
    output logic                ram_wren_o,
    output logic                ram_rden_o,
    input  logic [data_w-1:0]   ram_dout_i
);

    import axi_ram_pkg::*;

    logic              wr_load, wr_step, wr_last, wr_en;
    logic              rd_load, rd_step, rd_last;
    logic [addr_w-1:0] wr_addr, rd_addr;
    logic              push, push_last, pop;
    logic [data_w-1:0] push_data;
    logic [id_w-1:0]   push_id;

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------

    axi_ram_wr_ctrl #(.data_w(data_w), .id_w(id_w)) u_wr_ctrl (
        .clk_i, .rst_ni,
        .aw_valid_i, .aw_id_i, .aw_ready_o,
        .w_valid_i, .w_last_i, .w_strb_i, .w_ready_o,
        .b_valid_o, .b_id_o, .b_resp_o, .b_ready_i,
        .cnt_load_o(wr_load), .cnt_step_o(wr_step), .cnt_last_i(wr_last),
        .ram_wren_o(wr_en), .ram_wmask_o
    );

    axi_burst_addr #(.addr_w(addr_w), .data_w(data_w)) u_wr_addr (
        .clk_i, .rst_ni,
        .load_i(wr_load), .addr_i(aw_addr_i), .len_i(aw_len_i), .burst_i(aw_burst_i),
        .step_i(wr_step), .addr_o(wr_addr), .last_o(wr_last)
    );

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    // Write beat holds off read issue for that cycle
    axi_ram_rd_ctrl #(.data_w(data_w), .id_w(id_w), .read_latency(read_latency)) u_rd_ctrl (
        .clk_i, .rst_ni,
        .ar_valid_i, .ar_id_i, .ar_ready_o,
        .cnt_load_o(rd_load), .cnt_step_o(rd_step), .cnt_last_i(rd_last),
        .hold_i(wr_en), .ram_rden_o, .ram_dout_i,
        .push_o(push), .push_data_o(push_data), .push_id_o(push_id),
        .push_last_o(push_last), .pop_i(pop)
    );

    axi_burst_addr #(.addr_w(addr_w), .data_w(data_w)) u_rd_addr (
        .clk_i, .rst_ni,
        .load_i(rd_load), .addr_i(ar_addr_i), .len_i(ar_len_i), .burst_i(ar_burst_i),
        .step_i(rd_step), .addr_o(rd_addr), .last_o(rd_last)
    );

    axi_r_fifo2 #(.data_w(data_w), .id_w(id_w)) u_r_fifo (
        .clk_i, .rst_ni,
        .push_i(push), .data_i(push_data), .id_i(push_id), .last_i(push_last),
        .valid_o(r_valid_o), .data_o(r_data_o), .id_o(r_id_o), .last_o(r_last_o),
        .ready_i(r_ready_i)
    );

    // R handshake returns a read credit
    assign pop      = r_valid_o & r_ready_i;
    assign r_resp_o = RESP_OKAY;

    // ------------------------------------------------------------------------
    // RAM port
    // ------------------------------------------------------------------------

    // Write address wins while a write beat is accepted
    assign ram_addr_o = wr_en ? wr_addr : rd_addr;
    assign ram_din_o  = w_data_i;
    assign ram_wren_o = wr_en;

endmodule

//--- logic/axi_r_fifo2.sv
// Two-entry R channel register
module axi_r_fifo2 #(
    parameter int unsigned data_w = axi_ram_pkg::DEF_DATA_W,
    parameter int unsigned id_w   = axi_ram_pkg::DEF_ID_W
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Beats from the read controller
    input  logic              push_i,
    input  logic [data_w-1:0] data_i,
    input  logic [id_w-1:0]   id_i,
    input  logic              last_i,
    // AXI R channel
    output logic              valid_o,
    output logic [data_w-1:0] data_o,
    output logic [id_w-1:0]   id_o,
    output logic              last_o,
    input  logic              ready_i
);

    logic [data_w-1:0] data_q [2];
    logic [id_w-1:0]   id_q   [2];
    logic [1:0]        last_q;
    logic              wr_ptr_q;
    logic              rd_ptr_q;
    logic [1:0]        cnt_q;
    logic              pop;

    assign valid_o = (cnt_q != 2'd0);
    assign pop     = valid_o & ready_i;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push_i) wr_ptr_q <= ~wr_ptr_q;
            if (pop) rd_ptr_q <= ~rd_ptr_q;
            cnt_q <= cnt_q + {1'b0, push_i} - {1'b0, pop};
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            data_q[wr_ptr_q] <= data_i;
            id_q[wr_ptr_q]   <= id_i;
            last_q[wr_ptr_q] <= last_i;
        end
    end

    // Head of queue drives the bus
    assign data_o = data_q[rd_ptr_q];
    assign id_o   = id_q[rd_ptr_q];
    assign last_o = last_q[rd_ptr_q];

    // Read credits upstream keep a full register from being pushed
    no_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(push_i && (cnt_q == 2'd2) && !pop)
    ) else $error("R register overflow");

endmodule

//--- logic/axi_ram_rd_ctrl.sv
// AXI read channel controller
module axi_ram_rd_ctrl #(
    parameter int unsigned data_w       = axi_ram_pkg::DEF_DATA_W,
    parameter int unsigned id_w         = axi_ram_pkg::DEF_ID_W,
    parameter int unsigned read_latency = axi_ram_pkg::DEF_RD_LAT
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // AR channel
    input  logic              ar_valid_i,
    input  logic [id_w-1:0]   ar_id_i,
    output logic              ar_ready_o,
    // Burst counter
    output logic              cnt_load_o,
    output logic              cnt_step_o,
    input  logic              cnt_last_i,
    // Write beat owns the RAM this cycle
    input  logic              hold_i,
    // RAM read port
    output logic              ram_rden_o,
    input  logic [data_w-1:0] ram_dout_i,
    // Output register
    output logic              push_o,
    output logic [data_w-1:0] push_data_o,
    output logic [id_w-1:0]   push_id_o,
    output logic              push_last_o,
    input  logic              pop_i
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } state_e;

    state_e                  state_q, state_d;
    logic [id_w-1:0]         id_q;
    logic [1:0]              credit_q, credit_d;
    logic [read_latency-1:0] pipe_vld_q;
    logic [read_latency-1:0] pipe_last_q;
    logic                    ar_hs;
    logic                    issue;

    assign ar_ready_o = (state_q == IDLE);
    assign ar_hs      = ar_valid_i & ar_ready_o;
    assign cnt_load_o = ar_hs;

    // Issue needs a free output slot and a RAM not taken by a write
    assign issue      = (state_q == ISSUE) && (credit_q != 2'd0) && !hold_i;
    assign ram_rden_o = issue;
    assign cnt_step_o = issue & ~cnt_last_i;

    // ------------------------------------------------------------------------
    // FSM and credits
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:  if (ar_hs) state_d = ISSUE;
            ISSUE: if (issue && cnt_last_i) state_d = DRAIN;
            // Last outstanding beat leaves on this pop
            DRAIN: if (pop_i && (credit_q == 2'd1)) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // One credit per output register entry
    always_comb begin
        credit_d = credit_q;
        if (issue) credit_d = credit_d - 2'd1;
        if (pop_i) credit_d = credit_d + 2'd1;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            credit_q   <= 2'd2;
            pipe_vld_q <= '0;
        end else begin
            state_q       <= state_d;
            credit_q      <= credit_d;
            pipe_vld_q[0] <= issue;
            for (int i = 1; i < read_latency; i++) begin
                pipe_vld_q[i] <= pipe_vld_q[i-1];
            end
        end
    end

    // ------------------------------------------------------------------------
    // RAM latency pipeline
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            id_q <= ar_id_i;
        end
        pipe_last_q[0] <= issue & cnt_last_i;
        for (int i = 1; i < read_latency; i++) begin
            pipe_last_q[i] <= pipe_last_q[i-1];
        end
    end

    // RAM data lines up with the end of the pipeline
    assign push_o      = pipe_vld_q[read_latency-1];
    assign push_last_o = pipe_last_q[read_latency-1];
    assign push_data_o = ram_dout_i;
    assign push_id_o   = id_q;

    // A pop always matches an issued beat, so credits stay in range
    credit_range: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (credit_q <= 2'd2) && !(pop_i && (credit_q == 2'd2))
    ) else $error("read credit count out of range");

endmodule

//--- logic/axi_ram_wr_ctrl.sv
// AXI write channel controller
module axi_ram_wr_ctrl #(
    parameter int unsigned data_w = axi_ram_pkg::DEF_DATA_W,
    parameter int unsigned id_w   = axi_ram_pkg::DEF_ID_W
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // AW channel
    input  logic                 aw_valid_i,
    input  logic [id_w-1:0]      aw_id_i,
    output logic                 aw_ready_o,
    // W channel
    input  logic                 w_valid_i,
    input  logic                 w_last_i,
    input  logic [data_w/8-1:0]  w_strb_i,
    output logic                 w_ready_o,
    // B channel
    output logic                 b_valid_o,
    output logic [id_w-1:0]      b_id_o,
    output axi_ram_pkg::resp_e   b_resp_o,
    input  logic                 b_ready_i,
    // Burst counter
    output logic                 cnt_load_o,
    output logic                 cnt_step_o,
    input  logic                 cnt_last_i,
    // RAM write port
    output logic                 ram_wren_o,
    output logic [data_w-1:0]    ram_wmask_o
);

    import axi_ram_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        RESP
    } state_e;

    state_e          state_q, state_d;
    logic [id_w-1:0] id_q;
    logic            aw_hs;
    logic            w_hs;

    // ------------------------------------------------------------------------
    // Handshakes and outputs decoded from state
    // ------------------------------------------------------------------------

    assign aw_ready_o = (state_q == IDLE);
    assign w_ready_o  = (state_q == DATA);
    assign b_valid_o  = (state_q == RESP);

    assign aw_hs = aw_valid_i & aw_ready_o;
    assign w_hs  = w_valid_i & w_ready_o;

    // Counter loads on AW, steps on every beat except the final one
    assign cnt_load_o = aw_hs;
    assign cnt_step_o = w_hs & ~cnt_last_i;

    // Every accepted beat goes straight to the RAM
    assign ram_wren_o = w_hs;

    // One strobe bit covers eight mask bits
    always_comb begin
        for (int i = 0; i < data_w / 8; i++) begin
            ram_wmask_o[i*8 +: 8] = {8{w_strb_i[i]}};
        end
    end

    assign b_id_o   = id_q;
    assign b_resp_o = RESP_OKAY;

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (aw_hs) state_d = DATA;
            DATA: if (w_hs && cnt_last_i) state_d = RESP;
            RESP: if (b_ready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // AWID echoed on BID
    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            id_q <= aw_id_i;
        end
    end

    // Master's WLAST must line up with the AWLEN beat count
    wlast_matches_len: assert property (
        @(posedge clk_i) disable iff (!rst_ni) w_hs |-> (w_last_i == cnt_last_i)
    ) else $error("WLAST disagrees with burst length");

endmodule

//--- logic/axi_burst_addr.sv
// Burst address and beat counter
module axi_burst_addr #(
    parameter int unsigned addr_w = axi_ram_pkg::DEF_ADDR_W,
    parameter int unsigned data_w = axi_ram_pkg::DEF_DATA_W
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                load_i,
    input  logic [addr_w-1:0]   addr_i,
    input  axi_ram_pkg::len_t   len_i,
    input  axi_ram_pkg::burst_e burst_i,
    input  logic                step_i,
    output logic [addr_w-1:0]   addr_o,
    output logic                last_o
);

    import axi_ram_pkg::*;

    // Byte-lane bits below the word address
    localparam int unsigned lsb_w = $clog2(data_w / 8);

    logic [addr_w-1:0] addr_q;
    burst_e            burst_q;
    len_t              len_q;
    len_t              cnt_q;

    // ------------------------------------------------------------------------
    // Burst state and beat count
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            burst_q <= BURST_FIXED;
            len_q   <= '0;
            cnt_q   <= '0;
        end else if (load_i) begin
            // New burst starts at beat zero
            burst_q <= burst_i;
            len_q   <= len_i;
            cnt_q   <= '0;
        end else if (step_i) begin
            cnt_q <= cnt_q + 8'd1;
        end
    end

    // ------------------------------------------------------------------------
    // Current address
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            addr_q <= addr_i;
        end else if (step_i && (burst_q == BURST_INCR)) begin
            // Next data word, byte offset untouched
            addr_q[addr_w-1:lsb_w] <= addr_q[addr_w-1:lsb_w] + 1'b1;
        end
        // FIXED, WRAP and reserved codes keep the address
    end

    assign addr_o = addr_q;

    // Final beat once the count reaches AxLEN
    assign last_o = (cnt_q == len_q);

    // Controller must not advance a burst in the cycle it loads one
    step_during_load: assert property (
        @(posedge clk_i) disable iff (!rst_ni) load_i |-> !step_i
    ) else $error("burst counter stepped during load");

endmodule

//--- logic/axi_ram_pkg.sv
// AXI RAM bridge definitions
package axi_ram_pkg;

    // ------------------------------------------------------------------------
    // AXI burst and response codes
    // ------------------------------------------------------------------------

    // Burst type as carried on AWBURST and ARBURST
    // Only INCR advances the address, every other code holds it
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    // Response code as carried on BRESP and RRESP
    // This slave never reports an error
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Burst length field, beats minus one
    typedef logic [7:0] len_t;

    // ------------------------------------------------------------------------
    // Default sizes
    // ------------------------------------------------------------------------

    // Address and data bus widths in bits
    localparam int unsigned DEF_ADDR_W = 32;
    localparam int unsigned DEF_DATA_W = 32;

    // Transaction ID width
    localparam int unsigned DEF_ID_W = 4;

    // RAM read latency in cycles
    localparam int unsigned DEF_RD_LAT = 2;

endpackage
